/* hdl/cpu_bus_pkg.sv */
// request and response structs of the cpu bus
// a request with a zero write strobe is a read

`include "soc_macros.svh"

package cpu_bus_pkg;

    // held by the cpu from valid until it sees ready
    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] addr;
        logic [`SOC_DATA_W-1:0] wdata;
        logic [3:0] wstrb;
        logic valid;
    } cpu_req_t;

    // ready is a single cycle pulse on the 1x side and a level on the 2x side
    typedef struct packed {
        logic [`SOC_DATA_W-1:0] rdata;
        logic ready;
    } cpu_rsp_t;

endpackage

/* hdl/cpu_peripheral_sync.sv */
// clock bridge between the clk_1x cpu bus and the clk_2x peripheral bus
// requests and eoi go up through a 1x capture and a 2x falling edge stage
// responses and interrupts come back through falling edge 2x registers
// the rising edge of ready becomes a single clk_1x pulse

`timescale 1ns/1ps
`include "soc_macros.svh"

module cpu_peripheral_sync (
    input logic clk_1x,
    input logic clk_2x,
    input logic reset,
    input cpu_bus_pkg::cpu_req_t cpu_req,
    input logic [`SOC_IRQ_COUNT-1:0] cpu_eoi,
    input cpu_bus_pkg::cpu_rsp_t rsp_2x,
    input logic [`SOC_IRQ_COUNT-1:0] irq_2x,
    output cpu_bus_pkg::cpu_req_t req_2x,
    output logic [`SOC_IRQ_COUNT-1:0] eoi_2x,
    output cpu_bus_pkg::cpu_rsp_t cpu_rsp,
    output logic [`SOC_IRQ_COUNT-1:0] cpu_irq
);

    cpu_bus_pkg::cpu_req_t req_r;
    logic [`SOC_IRQ_COUNT-1:0] eoi_r;

    logic [`SOC_DATA_W-1:0] rdata_r;
    logic ready_r;
    logic ready_d;
    logic ready_rose;
    logic [`SOC_IRQ_COUNT-1:0] irq_r;

    // capture on the cpu clock
    always_ff @(posedge clk_1x) begin
        if (reset) begin
            req_r.valid <= 1'b0;
            eoi_r <= '0;
        end else begin
            req_r <= cpu_req;
            eoi_r <= cpu_eoi;
        end
    end

    // half a 2x cycle later the request lands in the peripheral domain
    always_ff @(negedge clk_2x) begin
        if (reset) begin
            req_2x.valid <= 1'b0;
            eoi_2x <= '0;
        end else begin
            req_2x <= req_r;
            eoi_2x <= eoi_r;
        end
    end

    // the return path registers ready twice to find its rising edge
    always_ff @(negedge clk_2x) begin
        if (reset) begin
            ready_r <= 1'b0;
            ready_d <= 1'b0;
            ready_rose <= 1'b0;
            irq_r <= '0;
        end else begin
            ready_r <= rsp_2x.ready;
            ready_d <= ready_r;
            ready_rose <= ready_r && !ready_d;
            irq_r <= irq_2x;
        end
    end

    always_ff @(negedge clk_2x) begin
        rdata_r <= rsp_2x.rdata;
    end

    // the falling edge to 1x rising edge hop leaves half a 2x cycle for cpu logic
    always_ff @(posedge clk_1x) begin
        if (reset) begin
            cpu_rsp.ready <= 1'b0;
            cpu_irq <= '0;
        end else begin
            cpu_rsp.ready <= ready_rose;
            cpu_irq <= irq_r;
        end
        cpu_rsp.rdata <= rdata_r;
    end

    // one edge of the 2x ready level must give one 1x pulse
    assert property (@(posedge clk_1x) disable iff (reset)
        cpu_rsp.ready |=> !cpu_rsp.ready)
        else $error("cpu_rsp ready held for more than one clk_1x cycle");

endmodule

/* hdl/irq_ctrl.sv */
// interrupt controller on the clk_2x bus
// pending bits set by event pulses and cleared by eoi
// mask register, and a registered masked interrupt output

`timescale 1ns/1ps
`include "soc_macros.svh"

module irq_ctrl (
    input logic clk_2x,
    input logic reset,
    input logic wr_en,
    input logic [3:0] word_index,
    input logic [`SOC_DATA_W-1:0] wdata,
    input logic [`SOC_IRQ_COUNT-1:0] irq_events,
    input logic [`SOC_IRQ_COUNT-1:0] eoi_2x,
    output logic [`SOC_DATA_W-1:0] rdata,
    output logic [`SOC_IRQ_COUNT-1:0] irq_2x
);

    logic [`SOC_IRQ_COUNT-1:0] pending;
    logic [`SOC_IRQ_COUNT-1:0] mask;

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            pending <= '0;
            mask <= '0;
            irq_2x <= '0;
        end else begin
            // a new event wins over an eoi for the same line
            pending <= (pending & ~eoi_2x) | irq_events;
            if (wr_en && (word_index == periph_pkg::irq_reg_mask)) begin
                mask <= wdata;
            end
            irq_2x <= pending & mask;
        end
    end

    // pending is read only, writes to it are dropped
    always_comb begin
        case (word_index)
            periph_pkg::irq_reg_mask: rdata = mask;
            periph_pkg::irq_reg_pending: rdata = pending;
            default: rdata = '0;
        endcase
    end

endmodule

/* hdl/periph_bus_decoder.sv */
// address decoder of the clk_2x peripheral bus
// selects scratch or interrupt controller from address bits 23..20
// writes once per request and returns a registered ready level and read word

`timescale 1ns/1ps
`include "soc_macros.svh"

module periph_bus_decoder (
    input logic clk_2x,
    input logic reset,
    input cpu_bus_pkg::cpu_req_t req_2x,
    input logic [`SOC_DATA_W-1:0] scratch_rdata,
    input logic [`SOC_DATA_W-1:0] irq_rdata,
    output logic wr_en_scratch,
    output logic wr_en_irq,
    output logic [3:0] wstrb,
    output logic [3:0] word_index,
    output logic [`SOC_DATA_W-1:0] wdata,
    output cpu_bus_pkg::cpu_rsp_t rsp_2x
);

    periph_pkg::periph_sel_t sel;
    logic valid_q;
    logic first_cycle;
    logic is_write;
    logic ready_q;
    logic [`SOC_DATA_W-1:0] rdata_next;
    logic [`SOC_DATA_W-1:0] rdata_q;

    always_comb begin
        case (req_2x.addr[`SOC_ADDR_W-1 -: 4])
            `SOC_REGION_SCRATCH: sel = periph_pkg::sel_scratch;
            `SOC_REGION_IRQ: sel = periph_pkg::sel_irq;
            default: sel = periph_pkg::sel_none;
        endcase
    end

    // a held valid must not write again
    assign first_cycle = req_2x.valid && !valid_q;
    assign is_write = |req_2x.wstrb;

    assign wr_en_scratch = first_cycle && is_write && (sel == periph_pkg::sel_scratch);
    assign wr_en_irq = first_cycle && is_write && (sel == periph_pkg::sel_irq);

    assign wstrb = req_2x.wstrb;
    assign word_index = req_2x.addr[5:2];
    assign wdata = req_2x.wdata;

    // unmapped regions read as zero
    always_comb begin
        case (sel)
            periph_pkg::sel_scratch: rdata_next = scratch_rdata;
            periph_pkg::sel_irq: rdata_next = irq_rdata;
            default: rdata_next = '0;
        endcase
    end

    // ready rises the cycle after the write and drops once valid is gone
    always_ff @(posedge clk_2x) begin
        if (reset) begin
            valid_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            valid_q <= req_2x.valid;
            ready_q <= req_2x.valid && valid_q;
        end
    end

    always_ff @(posedge clk_2x) begin
        rdata_q <= rdata_next;
    end

    assign rsp_2x = '{rdata: rdata_q, ready: ready_q};

    assert property (@(posedge clk_2x) disable iff (reset)
        !(wr_en_scratch && wr_en_irq))
        else $error("scratch and irq write enables both active");

endmodule

/* hdl/periph_pkg.sv */
// peripheral select values of the address decoder
// word offsets of the interrupt controller registers

package periph_pkg;

    // result of decoding address bits 23..20
    typedef enum logic [1:0] {
        sel_scratch = 2'd0,
        sel_irq = 2'd1,
        sel_none = 2'd2
    } periph_sel_t;

    // word index within the interrupt controller region
    // mask is read and write, pending is read only
    typedef enum logic [3:0] {
        irq_reg_mask = 4'd0,
        irq_reg_pending = 4'd1
    } irq_reg_t;

endpackage

/* hdl/periph_subsystem_top.sv */
// top of the peripheral subsystem
// clock bridge, clk_2x address decoder, scratch bank and interrupt controller

`timescale 1ns/1ps
`include "soc_macros.svh"

module periph_subsystem_top (
    input logic clk_1x,
    input logic clk_2x,
    input logic reset,
    input cpu_bus_pkg::cpu_req_t cpu_req,
    input logic [`SOC_IRQ_COUNT-1:0] cpu_eoi,
    input logic [`SOC_IRQ_COUNT-1:0] irq_events,
    output cpu_bus_pkg::cpu_rsp_t cpu_rsp,
    output logic [`SOC_IRQ_COUNT-1:0] cpu_irq
);

    cpu_bus_pkg::cpu_req_t req_2x;
    cpu_bus_pkg::cpu_rsp_t rsp_2x;
    logic [`SOC_IRQ_COUNT-1:0] eoi_2x;
    logic [`SOC_IRQ_COUNT-1:0] irq_2x;

    // peripheral bus between decoder and peripherals
    logic wr_en_scratch;
    logic wr_en_irq;
    logic [3:0] wstrb;
    logic [3:0] word_index;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_DATA_W-1:0] scratch_rdata;
    logic [`SOC_DATA_W-1:0] irq_rdata;

    cpu_peripheral_sync i_cpu_peripheral_sync (
        .clk_1x(clk_1x),
        .clk_2x(clk_2x),
        .reset(reset),
        .cpu_req(cpu_req),
        .cpu_eoi(cpu_eoi),
        .rsp_2x(rsp_2x),
        .irq_2x(irq_2x),
        .req_2x(req_2x),
        .eoi_2x(eoi_2x),
        .cpu_rsp(cpu_rsp),
        .cpu_irq(cpu_irq)
    );

    periph_bus_decoder i_periph_bus_decoder (
        .clk_2x(clk_2x),
        .reset(reset),
        .req_2x(req_2x),
        .scratch_rdata(scratch_rdata),
        .irq_rdata(irq_rdata),
        .wr_en_scratch(wr_en_scratch),
        .wr_en_irq(wr_en_irq),
        .wstrb(wstrb),
        .word_index(word_index),
        .wdata(wdata),
        .rsp_2x(rsp_2x)
    );

    scratch_regs i_scratch_regs (
        .clk_2x(clk_2x),
        .reset(reset),
        .wr_en(wr_en_scratch),
        .wstrb(wstrb),
        .word_index(word_index),
        .wdata(wdata),
        .rdata(scratch_rdata)
    );

    irq_ctrl i_irq_ctrl (
        .clk_2x(clk_2x),
        .reset(reset),
        .wr_en(wr_en_irq),
        .word_index(word_index),
        .wdata(wdata),
        .irq_events(irq_events),
        .eoi_2x(eoi_2x),
        .rdata(irq_rdata),
        .irq_2x(irq_2x)
    );

endmodule

/* hdl/scratch_regs.sv */
// bank of scratch registers on the clk_2x bus
// byte strobe writes, combinational read by word index

`timescale 1ns/1ps
`include "soc_macros.svh"

module scratch_regs (
    input logic clk_2x,
    input logic reset,
    input logic wr_en,
    input logic [3:0] wstrb,
    input logic [3:0] word_index,
    input logic [`SOC_DATA_W-1:0] wdata,
    output logic [`SOC_DATA_W-1:0] rdata
);

    logic [`SOC_DATA_W-1:0] words [`SOC_SCRATCH_WORDS];

    // sixteen words written by byte lane
    always_ff @(posedge clk_2x) begin
        if (reset) begin
            for (int i = 0; i < `SOC_SCRATCH_WORDS; i++) begin
                words[i] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                // only the strobed bytes change
                if (wstrb[b]) begin
                    words[word_index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign rdata = words[word_index];

endmodule

/* hdl/soc_macros.svh */
// bus widths for the cpu side and the peripheral side
// interrupt line count and scratch bank depth
// region codes in address bits 23..20

`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// cpu bus
`define SOC_ADDR_W 24
`define SOC_DATA_W 32

// one pending and one mask bit per line
`define SOC_IRQ_COUNT 32

// word count of the scratch register bank
`define SOC_SCRATCH_WORDS 16

// top nibble of the address picks the peripheral
`define SOC_REGION_SCRATCH 4'h0
`define SOC_REGION_IRQ 4'h1

`endif

/* project.f */
+incdir+hdl
hdl/cpu_bus_pkg.sv
hdl/periph_pkg.sv
hdl/cpu_peripheral_sync.sv
hdl/periph_bus_decoder.sv
hdl/scratch_regs.sv
hdl/irq_ctrl.sv
hdl/periph_subsystem_top.sv
verif/tb_periph_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_periph_subsystem \
    -o sim_tb || { echo "compile failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log && { echo "simulation passed"; exit 0; }
echo "simulation failed"
exit 1

/* verif/tb_periph_subsystem.sv */
// testbench of the peripheral subsystem
// clocks and reset, cpu bus driver, register model with a reference read
// response checker on every ready pulse, interrupt and eoi sequences

`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_periph_subsystem;

    localparam int READY_TIMEOUT = 20;
    localparam int IRQ_TIMEOUT = 8;

    // clk_2x starts high so that both rising edges line up
    logic clk_1x = 1'b0;
    logic clk_2x = 1'b1;
    logic reset;
    cpu_bus_pkg::cpu_req_t cpu_req;
    logic [`SOC_IRQ_COUNT-1:0] cpu_eoi;
    logic [`SOC_IRQ_COUNT-1:0] irq_events;
    cpu_bus_pkg::cpu_rsp_t cpu_rsp;
    logic [`SOC_IRQ_COUNT-1:0] cpu_irq;

    integer seed;
    int ready_count = 0;
    logic in_access = 1'b0;
    logic expect_read = 1'b0;
    logic [`SOC_DATA_W-1:0] expect_rdata;

    // register model
    logic [`SOC_DATA_W-1:0] model_scratch [`SOC_SCRATCH_WORDS];
    logic [`SOC_IRQ_COUNT-1:0] model_mask;
    logic [`SOC_IRQ_COUNT-1:0] model_pending;

    always #20 clk_1x = ~clk_1x;
    always #10 clk_2x = ~clk_2x;

    periph_subsystem_top i_periph_subsystem_top (
        .clk_1x(clk_1x),
        .clk_2x(clk_2x),
        .reset(reset),
        .cpu_req(cpu_req),
        .cpu_eoi(cpu_eoi),
        .irq_events(irq_events),
        .cpu_rsp(cpu_rsp),
        .cpu_irq(cpu_irq)
    );

    task automatic compare_values(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] wdata,
                                                input logic [3:0] strb);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // expected read word for an address, from the model
    function automatic logic [31:0] ref_read(input logic [`SOC_ADDR_W-1:0] addr);
        case (addr[23:20])
            `SOC_REGION_SCRATCH: return model_scratch[addr[5:2]];
            `SOC_REGION_IRQ: begin
                case (addr[5:2])
                    4'd0: return model_mask;
                    4'd1: return model_pending;
                    default: return '0;
                endcase
            end
            default: return '0;
        endcase
    endfunction

    function automatic logic [`SOC_ADDR_W-1:0] reg_addr(input logic [3:0] region,
                                                        input logic [3:0] idx);
        return {region, 14'h0, idx, 2'b00};
    endfunction

    task automatic update_model(input logic [`SOC_ADDR_W-1:0] addr,
                                input logic [31:0] wdata, input logic [3:0] strb);
        case (addr[23:20])
            `SOC_REGION_SCRATCH: begin
                model_scratch[addr[5:2]] = merge_bytes(model_scratch[addr[5:2]], wdata, strb);
            end
            `SOC_REGION_IRQ: begin
                // pending is read only
                if (addr[5:2] == 4'd0) begin
                    model_mask = wdata;
                end
            end
            default: ;
        endcase
    endtask

    // one request held until ready and then valid low for two cycles
    task automatic bus_access(input logic [`SOC_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb);
        int count_before;
        int waited;
        count_before = ready_count;
        expect_read = (strb == 4'h0);
        expect_rdata = ref_read(addr);
        in_access = 1'b1;
        @(posedge clk_1x);
        cpu_req <= '{addr: addr, wdata: wdata, wstrb: strb, valid: 1'b1};
        waited = 0;
        while (ready_count == count_before) begin
            @(posedge clk_1x);
            waited++;
            if (waited > READY_TIMEOUT) begin
                abort_run("timeout: no ready pulse for a bus request");
            end
        end
        cpu_req <= '0;
        if (!expect_read) begin
            update_model(addr, wdata, strb);
        end
        repeat (2) @(posedge clk_1x);
        compare_values("ready pulse count", 32'(ready_count - count_before), 32'd1);
        in_access = 1'b0;
    endtask

    task automatic pulse_events(input logic [31:0] bits);
        @(posedge clk_2x);
        irq_events <= bits;
        @(posedge clk_2x);
        irq_events <= '0;
        model_pending = model_pending | bits;
    endtask

    task automatic send_eoi(input logic [31:0] bits);
        @(posedge clk_1x);
        cpu_eoi <= bits;
        @(posedge clk_1x);
        cpu_eoi <= '0;
        model_pending = model_pending & ~bits;
    endtask

    task automatic check_quiet(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk_1x);
            compare_values("cpu_rsp.ready", 32'(cpu_rsp.ready), 32'd0);
            compare_values("cpu_irq", cpu_irq, 32'd0);
        end
    endtask

    task automatic wait_irq(input logic [31:0] expected);
        int waited;
        waited = 0;
        @(negedge clk_1x);
        while (cpu_irq !== expected) begin
            if (waited == IRQ_TIMEOUT) begin
                abort_run("timeout: cpu_irq never matched pending and mask");
            end
            waited++;
            @(negedge clk_1x);
        end
    endtask

    // outputs settle at the 1x rising edge, so sample at the falling edge
    always @(negedge clk_1x) begin
        if (!reset && cpu_rsp.ready) begin
            ready_count++;
            if (!in_access) begin
                abort_run("ready pulse seen with no request in flight");
            end
            if (expect_read) begin
                compare_values("cpu_rsp.rdata", cpu_rsp.rdata, expect_rdata);
            end
        end
    end

    initial begin
        logic [31:0] data;
        logic [3:0] strb;
        logic [3:0] idx;
        seed = 32'h9781_9bcf;
        reset = 1'b1;
        cpu_req = '0;
        cpu_eoi = '0;
        irq_events = '0;
        model_mask = '0;
        model_pending = '0;
        for (int i = 0; i < `SOC_SCRATCH_WORDS; i++) begin
            model_scratch[i] = '0;
        end
        repeat (10) @(posedge clk_1x);
        reset <= 1'b0;

        // quiet after reset with mask and pending clear
        check_quiet(4);
        bus_access(reg_addr(`SOC_REGION_IRQ, 4'd0), '0, 4'h0);
        bus_access(reg_addr(`SOC_REGION_IRQ, 4'd1), '0, 4'h0);

        // writes go to eight words so partial writes land on earlier data
        for (int i = 0; i < 12; i++) begin
            idx = 4'($random(seed)) & 4'h7;
            data = $random(seed);
            strb = (i < 4) ? 4'hf : 4'($random(seed));
            if (strb == 4'h0) begin
                strb = 4'h5;
            end
            bus_access(reg_addr(`SOC_REGION_SCRATCH, idx), data, strb);
            bus_access(reg_addr(`SOC_REGION_SCRATCH, idx), '0, 4'h0);
        end
        for (int i = 0; i < `SOC_SCRATCH_WORDS; i++) begin
            bus_access(reg_addr(`SOC_REGION_SCRATCH, 4'(i)), '0, 4'h0);
        end

        // unmapped region
        bus_access(reg_addr(4'h5, 4'h3), '0, 4'h0);

        // events while masked, then unmask
        pulse_events($random(seed) | 32'h0003_0003);
        pulse_events(32'h4000_0000);
        check_quiet(6);
        bus_access(reg_addr(`SOC_REGION_IRQ, 4'd1), '0, 4'h0);
        bus_access(reg_addr(`SOC_REGION_IRQ, 4'd0), $random(seed) | 32'h4001_0001, 4'hf);
        wait_irq(model_pending & model_mask);
        bus_access(reg_addr(`SOC_REGION_IRQ, 4'd0), '0, 4'h0);

        // bit 30 is outside the eoi and must survive
        send_eoi(model_pending & 32'h00ff_00ff);
        wait_irq(model_pending & model_mask);
        bus_access(reg_addr(`SOC_REGION_IRQ, 4'd1), '0, 4'h0);
        compare_values("cpu_irq", cpu_irq, model_pending & model_mask);

        $display("PASS: all tests");
        $finish;
    end

endmodule
